/* tb.f */
+incdir+.
radio_pkg.sv
reg_bus_if.sv
spi_slave.sv
reg_readback.sv
sys_ctrl.sv
io_ctrl.sv
radio_ctrl_top.sv
tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the radio control testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_top -Mdir "$OBJ_DIR" -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the result
if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tb_top.sv */
`default_nettype none

`include "radio_params.svh"

module tb_top;

  localparam int CLK_PERIOD  = 8;
  localparam int SEED        = 25328;
  localparam int HALF        = 4;   // SCK high and low time in clocks
  localparam int GAP         = 8;   // Byte gap, also the tail after SS rises
  localparam int SETTLE      = 10;  // Board inputs settle before a frame
  localparam int MAX_ENTRIES = 32;
  // One table entry: input setup, both bytes, the byte gap and the tail
  localparam int FRAME_CYCLES   = 2 + SETTLE + 2 * `SPI_BITS * 2 * HALF + 2 * GAP + HALF;
  localparam int TIMEOUT_CYCLES = 2 * MAX_ENTRIES * FRAME_CYCLES + 100;  // Twice the table

  // One SPI transaction and what must come back
  typedef struct packed {
    logic                  wr;      // Write frame
    logic [`RB_SEL_W-1:0]  sel;
    logic [`RB_IOC_W-1:0]  ioc;
    logic [`RB_DATA_W-1:0] data;    // Second byte on MOSI
    logic [4:0]            inputs;  // {button, config} held during the frame
    logic                  chk;     // Compare the MISO byte
    logic [`RB_DATA_W-1:0] exp;
  } entry_t;

  logic       i_glob_clock;
  logic       i_rst_b;
  logic       i_sck;
  logic       i_ss;
  logic       i_mosi;
  logic       i_button;
  logic [3:0] i_config;
  logic       o_miso;
  logic       o_rx_h_tx_l;
  logic       o_rx_h_tx_l_b;
  logic       o_tr_vc1;
  logic       o_tr_vc1_b;
  logic       o_tr_vc2;
  logic       o_shdn_rx_lna;
  logic       o_shdn_tx_lna;
  logic       o_mixer_en;
  logic       o_led0;
  logic       o_led1;
  logic [3:0] o_tx_sample_gap;

  entry_t     tbl [MAX_ENTRIES];
  int         n_entries;
  int         cycle_cnt = 0;

  // Expected register state, tracked from the writes in the table
  logic [2:0] exp_mode;
  logic [1:0] exp_led;
  logic [3:0] exp_gap;

  radio_ctrl_top dut0 (
    .i_glob_clock    (i_glob_clock),
    .i_rst_b         (i_rst_b),
    .i_sck           (i_sck),
    .i_ss            (i_ss),
    .i_mosi          (i_mosi),
    .o_miso          (o_miso),
    .i_button        (i_button),
    .i_config        (i_config),
    .o_rx_h_tx_l     (o_rx_h_tx_l),
    .o_rx_h_tx_l_b   (o_rx_h_tx_l_b),
    .o_tr_vc1        (o_tr_vc1),
    .o_tr_vc1_b      (o_tr_vc1_b),
    .o_tr_vc2        (o_tr_vc2),
    .o_shdn_rx_lna   (o_shdn_rx_lna),
    .o_shdn_tx_lna   (o_shdn_tx_lna),
    .o_mixer_en      (o_mixer_en),
    .o_led0          (o_led0),
    .o_led1          (o_led1),
    .o_tx_sample_gap (o_tx_sample_gap)
  );

  initial begin
    i_glob_clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_glob_clock = ~i_glob_clock;
  end

  // Watchdog
  always @(posedge i_glob_clock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the frame sequence did not finish within %0d clock cycles",
               TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // ====================
  // Helpers
  // ====================
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge i_glob_clock);
  endtask

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [7:0] got,
                                 input logic [7:0] exp);
    $display("FAIL at %0t: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
    stop_with_failure();
  endtask

  // Pin pattern per RF mode, in port order rx, rx_b, vc1, vc1_b, vc2, shdn_rx, shdn_tx, mixer
  function automatic logic [7:0] expected_rf(input logic [2:0] mode);
    logic [5:0] p;  // rx, vc1, vc2, shdn_rx, shdn_tx, mixer
    case (mode)
      radio_pkg::RF_LOW_POWER:  p = 6'b111_110;
      radio_pkg::RF_BYPASS:     p = 6'b100_110;
      radio_pkg::RF_RX_LOWPASS: p = 6'b110_011;
      radio_pkg::RF_RX_HIPASS:  p = 6'b101_011;
      radio_pkg::RF_TX_LOWPASS: p = 6'b010_101;
      radio_pkg::RF_TX_HIPASS:  p = 6'b001_101;
      default:                  p = 6'b111_110;  // Codes 6 and 7 act as low power
    endcase
    return {p[5], ~p[5], p[4], ~p[4], p[3], p[2], p[1], p[0]};
  endfunction

  // Compares every board output with the tracked state
  task automatic check_outputs(input string when);
    logic [7:0] rf_got;
    @(negedge i_glob_clock);  // Away from the DUT's clock edge
    rf_got = {o_rx_h_tx_l, o_rx_h_tx_l_b, o_tr_vc1, o_tr_vc1_b,
              o_tr_vc2, o_shdn_rx_lna, o_shdn_tx_lna, o_mixer_en};
    assert ((o_rx_h_tx_l !== o_rx_h_tx_l_b) && (o_tr_vc1 !== o_tr_vc1_b))
      else report_mismatch({when, ": complement pairs"}, rf_got, expected_rf(exp_mode));
    assert (rf_got === expected_rf(exp_mode))
      else report_mismatch({when, ": RF pins"}, rf_got, expected_rf(exp_mode));
    assert ({o_led1, o_led0} === exp_led)
      else report_mismatch({when, ": LEDs"}, {6'b0, o_led1, o_led0}, {6'b0, exp_led});
    assert (o_tx_sample_gap === exp_gap)
      else report_mismatch({when, ": sample gap"}, {4'b0, o_tx_sample_gap}, {4'b0, exp_gap});
  endtask

  // ====================
  // SPI host
  // ====================
  // Mode 0, MSB first; MISO read just before each rising SCK of the data byte
  task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] wbyte,
                           output logic [7:0] rbyte);
    logic [15:0] tx;
    logic [7:0]  rx;
    tx = {cmd, wbyte};
    rx = '0;
    @(posedge i_glob_clock);
    i_ss   <= 1'b0;
    i_mosi <= tx[15];  // First bit set up while SCK is low
    for (int b = 0; b < 2 * `SPI_BITS; b++) begin
      if (b == `SPI_BITS) begin
        wait_clocks(GAP);  // DUT fetches the read byte here
      end
      wait_clocks(HALF - 1);
      @(negedge i_glob_clock);
      if (b >= `SPI_BITS) begin
        rx = {rx[6:0], o_miso};  // Settled since the last falling SCK
      end
      @(posedge i_glob_clock);
      i_sck <= 1'b1;
      wait_clocks(HALF);
      i_sck  <= 1'b0;
      tx     = {tx[14:0], 1'b0};
      i_mosi <= tx[15];  // Next bit on the falling edge
    end
    wait_clocks(HALF);
    i_ss <= 1'b1;
    wait_clocks(GAP);
    rbyte = rx;
  endtask

  // ====================
  // Stimulus table
  // ====================
  task automatic add_entry(input logic wr, input logic [1:0] sel, input logic [4:0] ioc,
                           input logic [7:0] data, input logic [4:0] inputs,
                           input logic chk, input logic [7:0] exp);
    if (n_entries >= MAX_ENTRIES) begin
      $display("The stimulus table holds more than %0d entries", MAX_ENTRIES);
      stop_with_failure();
    end else begin
      tbl[n_entries].wr     = wr;
      tbl[n_entries].sel    = sel;
      tbl[n_entries].ioc    = ioc;
      tbl[n_entries].data   = data;
      tbl[n_entries].inputs = inputs;
      tbl[n_entries].chk    = chk;
      tbl[n_entries].exp    = exp;
      n_entries++;
    end
  endtask

  task automatic add_read(input logic [1:0] sel, input logic [4:0] ioc,
                          input logic [4:0] inputs, input logic [7:0] exp);
    add_entry(1'b0, sel, ioc, 8'h00, inputs, 1'b1, exp);
  endtask

  task automatic add_write(input logic [1:0] sel, input logic [4:0] ioc,
                           input logic [7:0] data);
    add_entry(1'b1, sel, ioc, data, 5'h00, 1'b0, 8'h00);
  endtask

  // Mode write plus its readback
  task automatic add_mode(input logic [2:0] code);
    add_write(`RB_SEL_W'(`SEL_IO), 5'd1, {5'b0, code});
    add_read(`RB_SEL_W'(`SEL_IO), 5'd1, 5'h00, {5'b0, code});
  endtask

  task automatic build_table();
    logic [7:0] gap_byte;
    logic [7:0] led_byte;
    logic [4:0] in_a;
    logic [4:0] in_b;
    // Nonzero so that the writes differ from the reset state
    do begin
      gap_byte = 8'($urandom);
    end while (gap_byte[3:0] == 4'h0);
    do begin
      led_byte = 8'($urandom);
    end while (led_byte[1:0] == 2'b00);
    in_a      = 5'($urandom);
    in_b      = 5'($urandom);
    n_entries = 0;
    // System block: IDs, unmapped address, sample gap
    add_read(`RB_SEL_W'(`SEL_SYS), 5'd0, 5'h00, `SYS_VERSION);
    add_read(`RB_SEL_W'(`SEL_SYS), 5'd1, 5'h00, `SYS_BOARD_ID);
    add_read(`RB_SEL_W'(`SEL_SYS), 5'd9, 5'h00, 8'h00);
    add_write(`RB_SEL_W'(`SEL_SYS), 5'd2, gap_byte);
    add_read(`RB_SEL_W'(`SEL_SYS), 5'd2, 5'h00, {4'h0, gap_byte[3:0]});
    add_write(`RB_SEL_W'(`SEL_SYS), 5'd6, ~gap_byte);  // Unmapped, dropped
    add_read(`RB_SEL_W'(`SEL_SYS), 5'd2, 5'h00, {4'h0, gap_byte[3:0]});
    // Every RF mode code, ending back in low power
    add_mode(radio_pkg::RF_BYPASS);
    add_mode(radio_pkg::RF_RX_LOWPASS);
    add_mode(radio_pkg::RF_RX_HIPASS);
    add_mode(radio_pkg::RF_TX_LOWPASS);
    add_mode(radio_pkg::RF_TX_HIPASS);
    add_mode(3'd6);
    add_mode(3'd7);
    add_mode(radio_pkg::RF_LOW_POWER);
    // LEDs and board inputs
    add_write(`RB_SEL_W'(`SEL_IO), 5'd2, led_byte);
    add_read(`RB_SEL_W'(`SEL_IO), 5'd2, 5'h00, {6'b0, led_byte[1:0]});
    add_read(`RB_SEL_W'(`SEL_IO), 5'd3, in_a, {3'b0, in_a});
    add_read(`RB_SEL_W'(`SEL_IO), 5'd3, in_b, {3'b0, in_b});
    // Reserved selects
    add_read(2'd2, 5'd0, 5'h00, `RB_RESERVED_DATA);
    add_read(2'd3, 5'd17, 5'h00, `RB_RESERVED_DATA);
    add_write(2'd2, 5'd1, {5'b0, radio_pkg::RF_TX_HIPASS});  // Looks like a mode write
    add_write(2'd3, 5'd2, {6'b0, ~led_byte[1:0]});            // Looks like an LED write
    add_read(`RB_SEL_W'(`SEL_SYS), 5'd2, 5'h00, {4'h0, gap_byte[3:0]});
  endtask

  // Plays one table entry and checks the result
  task automatic apply_entry(input entry_t e, input int idx);
    logic [7:0] rbyte;
    string      tag;
    tag = $sformatf("entry %0d (sel %0d, ioc %0d)", idx, e.sel, e.ioc);
    @(posedge i_glob_clock);
    {i_button, i_config} <= e.inputs;
    wait_clocks(SETTLE);  // Through the input synchronizers
    spi_frame({e.wr, e.sel, e.ioc}, e.data, rbyte);
    if (e.wr) begin
      case (e.sel)
        `RB_SEL_W'(`SEL_SYS): begin
          if (e.ioc == 5'd2) exp_gap = e.data[3:0];
        end
        `RB_SEL_W'(`SEL_IO): begin
          if (e.ioc == 5'd1) exp_mode = e.data[2:0];
          if (e.ioc == 5'd2) exp_led = e.data[1:0];
        end
        default: ;  // Reserved, nothing behind it
      endcase
    end
    if (e.chk) begin
      assert (rbyte === e.exp)
        else report_mismatch({tag, ": readback"}, rbyte, e.exp);
    end
    check_outputs(tag);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    void'($urandom(SEED));
    i_rst_b  <= 1'b0;
    i_sck    <= 1'b0;
    i_ss     <= 1'b1;  // Deselected
    i_mosi   <= 1'b0;
    i_button <= 1'b0;
    i_config <= 4'h0;
    exp_mode = radio_pkg::RF_LOW_POWER;
    exp_led  = 2'b00;
    exp_gap  = 4'h0;
    build_table();
    repeat (2) @(posedge i_glob_clock);
    i_rst_b <= 1'b1;
    wait_clocks(4);
    check_outputs("after reset");
    assert (o_miso === 1'b0)
      else report_mismatch("after reset: MISO", {7'b0, o_miso}, 8'h00);
    for (int i = 0; i < n_entries; i++) begin
      apply_entry(tbl[i], i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* radio_ctrl_top.sv */
`default_nettype none

`include "radio_params.svh"

module radio_ctrl_top (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,

  // SPI from the microcontroller
  input  logic       i_sck,
  input  logic       i_ss,
  input  logic       i_mosi,
  output logic       o_miso,

  // Board inputs
  input  logic       i_button,
  input  logic [3:0] i_config,

  // RF front-end
  output logic       o_rx_h_tx_l,
  output logic       o_rx_h_tx_l_b,
  output logic       o_tr_vc1,
  output logic       o_tr_vc1_b,
  output logic       o_tr_vc2,
  output logic       o_shdn_rx_lna,
  output logic       o_shdn_tx_lna,
  output logic       o_mixer_en,

  output logic       o_led0,
  output logic       o_led1,
  output logic [3:0] o_tx_sample_gap
);

  logic [`RB_DATA_W-1:0] sys_rdata;
  logic [`RB_DATA_W-1:0] io_rdata;
  radio_pkg::rf_ctrl_t   rf;

  // ====================
  // Register bus
  // ====================
  reg_bus_if bus0 ();

  spi_slave spi_slave0 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_sck        (i_sck),
    .i_ss         (i_ss),
    .i_mosi       (i_mosi),
    .o_miso       (o_miso),
    .bus          (bus0.master)
  );

  reg_readback reg_readback0 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_sys_rdata  (sys_rdata),
    .i_io_rdata   (io_rdata),
    .bus          (bus0.sel)
  );

  // ====================
  // Peers
  // ====================
  sys_ctrl sys_ctrl0 (
    .i_glob_clock    (i_glob_clock),
    .i_rst_b         (i_rst_b),
    .bus             (bus0.peer),
    .o_rdata         (sys_rdata),
    .o_tx_sample_gap (o_tx_sample_gap)
  );

  io_ctrl io_ctrl0 (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_button     (i_button),
    .i_config     (i_config),
    .bus          (bus0.peer),
    .o_rdata      (io_rdata),
    .o_rf         (rf),
    .o_led0       (o_led0),
    .o_led1       (o_led1)
  );

  // RF control fields out to the pins
  assign o_rx_h_tx_l   = rf.rx_h_tx_l;
  assign o_rx_h_tx_l_b = rf.rx_h_tx_l_b;
  assign o_tr_vc1      = rf.tr_vc1;
  assign o_tr_vc1_b    = rf.tr_vc1_b;
  assign o_tr_vc2      = rf.tr_vc2;
  assign o_shdn_rx_lna = rf.shdn_rx_lna;
  assign o_shdn_tx_lna = rf.shdn_tx_lna;
  assign o_mixer_en    = rf.mixer_en;

endmodule

`default_nettype wire

/* io_ctrl.sv */
`default_nettype none

`include "radio_params.svh"

module io_ctrl (
  input  logic                  i_glob_clock,
  input  logic                  i_rst_b,
  input  logic                  i_button,
  input  logic [3:0]            i_config,
  reg_bus_if.peer               bus,
  output logic [`RB_DATA_W-1:0] o_rdata,
  output radio_pkg::rf_ctrl_t   o_rf,
  output logic                  o_led0,
  output logic                  o_led1
);

  // Register map
  localparam logic [`RB_IOC_W-1:0] IOC_RF_MODE = `RB_IOC_W'(1);
  localparam logic [`RB_IOC_W-1:0] IOC_LED     = `RB_IOC_W'(2);
  localparam logic [`RB_IOC_W-1:0] IOC_INPUTS  = `RB_IOC_W'(3);

  logic                          sel;
  radio_pkg::rf_mode_t           rf_mode_q;
  radio_pkg::rf_ctrl_t           rf_q;
  logic [1:0]                    led_q;
  logic [`SYNC_STAGES-1:0][4:0]  in_sync;  // {button, config} per stage
  logic [4:0]                    in_s;

  // Mode to switch pattern in rf_ctrl_t field order
  function automatic radio_pkg::rf_ctrl_t rf_decode(input radio_pkg::rf_mode_t mode);
    logic [7:0] pat;  // rx, rx_b, vc1, vc1_b, vc2, shdn_rx, shdn_tx, mixer
    case (mode)
      radio_pkg::RF_BYPASS:     pat = 8'b1001_0110;
      radio_pkg::RF_RX_LOWPASS: pat = 8'b1010_0011;
      radio_pkg::RF_RX_HIPASS:  pat = 8'b1001_1011;
      radio_pkg::RF_TX_LOWPASS: pat = 8'b0110_0101;
      radio_pkg::RF_TX_HIPASS:  pat = 8'b0101_1101;
      default:                  pat = 8'b1010_1110;  // Low power, also codes 6 and 7
    endcase
    return radio_pkg::rf_ctrl_t'(pat);
  endfunction

  assign sel = bus.cs[`SEL_IO];

  // ====================
  // Input synchronizers
  // ====================
  always_ff @(posedge i_glob_clock) begin
    in_sync <= {in_sync[`SYNC_STAGES-2:0], {i_button, i_config}};
  end

  assign in_s = in_sync[`SYNC_STAGES-1];

  // ====================
  // Registers
  // ====================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      rf_mode_q <= radio_pkg::RF_LOW_POWER;
      rf_q      <= rf_decode(radio_pkg::RF_LOW_POWER);
      led_q     <= '0;
    end else begin
      if (bus.load && sel) begin
        case (bus.ioc)
          IOC_RF_MODE: rf_mode_q <= radio_pkg::rf_mode_t'(bus.wdata[2:0]);  // Any code kept
          IOC_LED:     led_q     <= bus.wdata[1:0];
          default:     ;  // Inputs are read only
        endcase
      end
      rf_q <= rf_decode(rf_mode_q);  // One cycle behind the mode
    end
  end

  // Read path
  always_ff @(posedge i_glob_clock) begin
    if (bus.fetch && sel) begin
      case (bus.ioc)
        IOC_RF_MODE: o_rdata <= {{(`RB_DATA_W - 3){1'b0}}, rf_mode_q};
        IOC_LED:     o_rdata <= {{(`RB_DATA_W - 2){1'b0}}, led_q};
        IOC_INPUTS:  o_rdata <= {{(`RB_DATA_W - 5){1'b0}}, in_s};  // Button in bit 4
        default:     o_rdata <= '0;
      endcase
    end
  end

  assign o_rf   = rf_q;
  assign o_led0 = led_q[0];
  assign o_led1 = led_q[1];

  // Switch drivers must never see equal levels on a pair
  a_rf_pairs : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    (o_rf.rx_h_tx_l != o_rf.rx_h_tx_l_b) && (o_rf.tr_vc1 != o_rf.tr_vc1_b));

endmodule

`default_nettype wire

/* sys_ctrl.sv */
`default_nettype none

`include "radio_params.svh"

module sys_ctrl (
  input  logic                  i_glob_clock,
  input  logic                  i_rst_b,
  reg_bus_if.peer               bus,
  output logic [`RB_DATA_W-1:0] o_rdata,
  output logic [3:0]            o_tx_sample_gap
);

  // Register map
  localparam logic [`RB_IOC_W-1:0] IOC_VERSION  = `RB_IOC_W'(0);
  localparam logic [`RB_IOC_W-1:0] IOC_BOARD_ID = `RB_IOC_W'(1);
  localparam logic [`RB_IOC_W-1:0] IOC_GAP      = `RB_IOC_W'(2);

  logic       sel;
  logic [3:0] gap_q;  // TX sample gap

  assign sel = bus.cs[`SEL_SYS];

  // ====================
  // Read path
  // ====================
  always_ff @(posedge i_glob_clock) begin
    if (bus.fetch && sel) begin
      case (bus.ioc)
        IOC_VERSION:  o_rdata <= `SYS_VERSION;
        IOC_BOARD_ID: o_rdata <= `SYS_BOARD_ID;
        IOC_GAP:      o_rdata <= {{(`RB_DATA_W - 4){1'b0}}, gap_q};  // Upper bits zero
        default:      o_rdata <= '0;                                 // Unmapped
      endcase
    end
  end

  // ====================
  // Write path
  // ====================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      gap_q <= '0;
    end else if (bus.load && sel && (bus.ioc == IOC_GAP)) begin
      gap_q <= bus.wdata[3:0];  // Only the low nibble is kept
    end
  end

  assign o_tx_sample_gap = gap_q;

endmodule

`default_nettype wire

/* reg_readback.sv */
`default_nettype none

`include "radio_params.svh"

module reg_readback (
  input  logic                  i_glob_clock,
  input  logic                  i_rst_b,
  input  logic [`RB_DATA_W-1:0] i_sys_rdata,
  input  logic [`RB_DATA_W-1:0] i_io_rdata,
  reg_bus_if.sel                bus
);

  logic [`RB_DATA_W-1:0] rdata_q;

  // ====================
  // Peer select mux
  // ====================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      rdata_q <= '0;
    end else if (bus.cs[`SEL_SYS]) begin
      rdata_q <= i_sys_rdata;
    end else if (bus.cs[`SEL_IO]) begin
      rdata_q <= i_io_rdata;
    end else if (|bus.cs) begin
      rdata_q <= `RB_RESERVED_DATA;  // Selects with no peer behind them
    end else begin
      rdata_q <= '0;                 // Idle bus reads as zero
    end
  end

  assign bus.rdata = rdata_q;

  // The SPI slave must never raise two selects at once
  a_cs_onehot : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    $onehot0(bus.cs));

endmodule

`default_nettype wire

/* spi_slave.sv */
`default_nettype none

`include "radio_params.svh"

module spi_slave (
  input  logic      i_glob_clock,
  input  logic      i_rst_b,
  input  logic      i_sck,
  input  logic      i_ss,
  input  logic      i_mosi,
  output logic      o_miso,
  reg_bus_if.master bus
);

  localparam int CNT_W = $clog2(2 * `SPI_BITS);  // Spans both bytes of a frame

  logic [`SYNC_STAGES-1:0] sck_sync;
  logic [`SYNC_STAGES-1:0] ss_sync;
  logic [`SYNC_STAGES-1:0] mosi_sync;
  logic                    sck_d;      // Synchronized SCK, one cycle late
  logic                    sck_s;
  logic                    ss_s;
  logic                    mosi_s;
  logic                    sck_rise;
  logic                    sck_fall;

  logic [CNT_W-1:0]        bit_cnt;
  logic [`SPI_BITS-1:0]    rx_shift;
  logic [`SPI_BITS-1:0]    rx_byte;    // Shift register with the bit being sampled
  radio_pkg::reg_cmd_t     cmd_next;
  radio_pkg::reg_cmd_t     cmd_q;
  logic [`RB_NUM_SEL-1:0]  sel_onehot;
  logic [`RB_NUM_SEL-1:0]  cs_q;
  logic [`RB_DATA_W-1:0]   wdata_q;
  logic                    fetch_q;
  logic                    load_q;
  logic [1:0]              fetch_pipe; // Waits out peer and readback registers
  logic [`SPI_BITS-1:0]    miso_shift;
  logic                    cmd_done;
  logic                    data_done;

  // ====================
  // Synchronizers
  // ====================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      sck_sync <= '0;
      ss_sync  <= '1;  // Start deselected
      sck_d    <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[`SYNC_STAGES-2:0], i_sck};
      ss_sync  <= {ss_sync[`SYNC_STAGES-2:0], i_ss};
      sck_d    <= sck_s;
    end
  end

  // Same depth as SCK so data and clock stay aligned
  always_ff @(posedge i_glob_clock) begin
    mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], i_mosi};
  end

  assign sck_s    = sck_sync[`SYNC_STAGES-1];
  assign ss_s     = ss_sync[`SYNC_STAGES-1];
  assign mosi_s   = mosi_sync[`SYNC_STAGES-1];
  assign sck_rise = sck_s & ~sck_d & ~ss_s;  // Only inside a frame
  assign sck_fall = ~sck_s & sck_d & ~ss_s;

  // ====================
  // Frame decode
  // ====================
  assign rx_byte   = {rx_shift[`SPI_BITS-2:0], mosi_s};
  assign cmd_done  = sck_rise && (bit_cnt == CNT_W'(`SPI_BITS - 1));      // 8th rise
  assign data_done = sck_rise && (bit_cnt == CNT_W'(2 * `SPI_BITS - 1));  // 16th rise

  always_comb begin
    cmd_next               = radio_pkg::reg_cmd_t'(rx_byte);
    sel_onehot             = '0;
    sel_onehot[cmd_next.sel] = 1'b1;
  end

  // Control state
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      bit_cnt    <= '0;
      cs_q       <= '0;
      fetch_q    <= 1'b0;
      load_q     <= 1'b0;
      fetch_pipe <= '0;
      miso_shift <= '0;
    end else begin
      fetch_q    <= cmd_done;
      load_q     <= data_done && cmd_q.write;  // Reads never strobe load
      fetch_pipe <= {fetch_pipe[0], fetch_q};
      if (ss_s) begin
        bit_cnt <= '0;  // Frame over
        cs_q    <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;  // Wraps after the 16th bit
        if (cmd_done) begin
          cs_q <= sel_onehot;
        end
      end
      // Read byte arrives four cycles after the command
      if (fetch_pipe[1]) begin
        miso_shift <= bus.rdata;
      end else if (sck_fall && (bit_cnt > CNT_W'(`SPI_BITS))) begin
        miso_shift <= {miso_shift[`SPI_BITS-2:0], 1'b0};  // Next bit on falling SCK
      end
    end
  end

  // Payload registers
  always_ff @(posedge i_glob_clock) begin
    if (sck_rise) begin
      rx_shift <= rx_byte;  // MSB first
    end
    if (cmd_done) begin
      cmd_q <= cmd_next;
    end
    if (data_done && cmd_q.write) begin
      wdata_q <= rx_byte;
    end
  end

  // ====================
  // Bus and MISO
  // ====================
  assign bus.ioc   = cmd_q.ioc;
  assign bus.cs    = cs_q;
  assign bus.wdata = wdata_q;
  assign bus.fetch = fetch_q;
  assign bus.load  = load_q;

  assign o_miso = miso_shift[`SPI_BITS-1] & ~ss_s;  // Low when deselected

  // Strobes belong to different bytes of a frame
  a_fetch_load_excl : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    !(fetch_q && load_q));

endmodule

`default_nettype wire

/* reg_bus_if.sv */
`default_nettype none

`include "radio_params.svh"

// Shared register bus between the SPI slave and the peers
interface reg_bus_if;

  logic [`RB_IOC_W-1:0]   ioc;    // Register address, valid with cs
  logic [`RB_DATA_W-1:0]  wdata;  // Write data, valid with load
  logic [`RB_NUM_SEL-1:0] cs;     // One-hot peer select
  logic                   fetch;  // Read strobe, one cycle
  logic                   load;   // Write strobe, one cycle
  logic [`RB_DATA_W-1:0]  rdata;  // Registered read data of the selected peer

  // SPI slave side
  modport master (output ioc, wdata, cs, fetch, load, input rdata);

  // Register peers
  modport peer (input ioc, wdata, cs, fetch, load);

  // Readback selector
  modport sel (input cs, output rdata);

endinterface

`default_nettype wire

/* radio_pkg.sv */
`default_nettype none

`include "radio_params.svh"

package radio_pkg;

  // ====================
  // SPI command byte
  // ====================
  // Bit 7 first on the wire, then the select, then the address
  typedef struct packed {
    logic                 write;  // 1 = write, 0 = read
    logic [`RB_SEL_W-1:0] sel;    // Peer select
    logic [`RB_IOC_W-1:0] ioc;    // Register address
  } reg_cmd_t;

  // ====================
  // RF path
  // ====================
  // Codes 6 and 7 fall back to low power in the decoder
  typedef enum logic [2:0] {
    RF_LOW_POWER  = 3'd0,
    RF_BYPASS     = 3'd1,
    RF_RX_LOWPASS = 3'd2,
    RF_RX_HIPASS  = 3'd3,
    RF_TX_LOWPASS = 3'd4,
    RF_TX_HIPASS  = 3'd5
  } rf_mode_t;

  // Front-end switch, LNA and mixer controls
  typedef struct packed {
    logic rx_h_tx_l;    // T/R switch, high for receive
    logic rx_h_tx_l_b;  // Complement of rx_h_tx_l
    logic tr_vc1;       // Filter switch control 1
    logic tr_vc1_b;     // Complement of tr_vc1
    logic tr_vc2;       // Filter switch control 2
    logic shdn_rx_lna;  // RX LNA shutdown
    logic shdn_tx_lna;  // TX LNA shutdown
    logic mixer_en;
  } rf_ctrl_t;

endpackage

`default_nettype wire

/* radio_params.svh */
`ifndef RADIO_PARAMS_SVH
`define RADIO_PARAMS_SVH

// Register bus geometry
`define RB_IOC_W    5   // Register address within a peer
`define RB_DATA_W   8   // One data byte per frame
`define RB_SEL_W    2   // Peer select field of the command
`define RB_NUM_SEL  4   // One-hot chip selects

// Peer select codes
`define SEL_SYS     0
`define SEL_IO      1

// Fixed read-only values
`define SYS_VERSION       8'h01
`define SYS_BOARD_ID      8'h5C
`define RB_RESERVED_DATA  8'hA5  // Returned by the unused selects

// Input sampling
`define SYNC_STAGES 2   // Flops per asynchronous input
`define SPI_BITS    8   // Bits in one SPI byte

`endif
